// ==== hw/cmd_seq_reg_pkg.sv ====
/* register map, memory size and control byte layout of the command sequencer,
   referenced by scoped name from the register block, the engine and the memory port */
package cmd_seq_reg_pkg;

    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 8;
    localparam int MEM_BYTES = 256;
    localparam int MEM_AW    = $clog2(MEM_BYTES);

    localparam logic [DATA_W-1:0] VERSION = 8'd1;

    // byte offsets on APB, 16-bit values are little-endian pairs
    localparam logic [ADDR_W-1:0] OFF_VERSION = 16'd0;  // write gives soft reset
    localparam logic [ADDR_W-1:0] OFF_START   = 16'd1;  // write starts, read is finish flag
    localparam logic [ADDR_W-1:0] OFF_CTRL    = 16'd2;
    localparam logic [ADDR_W-1:0] OFF_SIZE_LO = 16'd3;
    localparam logic [ADDR_W-1:0] OFF_SIZE_HI = 16'd4;
    localparam logic [ADDR_W-1:0] OFF_REP_LO  = 16'd5;
    localparam logic [ADDR_W-1:0] OFF_REP_HI  = 16'd6;
    localparam logic [ADDR_W-1:0] OFF_PRE_LO  = 16'd7;
    localparam logic [ADDR_W-1:0] OFF_PRE_HI  = 16'd8;
    localparam logic [ADDR_W-1:0] OFF_SUF_LO  = 16'd9;
    localparam logic [ADDR_W-1:0] OFF_SUF_HI  = 16'd10;
    localparam logic [ADDR_W-1:0] OFF_MEM     = 16'd16; // first byte of memory window

    typedef struct packed {
        logic [3:0] spare;
        logic       dis_start_pulse;
        logic [1:0] line_mode;       // see cmd_seq_line_pkg
        logic       en_ext_start;
    } ctrl_fields_t;

    // same byte seen as the bus image or as engine controls
    typedef union packed {
        logic [DATA_W-1:0] raw;
        ctrl_fields_t      fields;
    } ctrl_byte_u;

endpackage

// ==== hw/cmd_seq_line_pkg.sv ====
/* line coding modes and playback engine states */
package cmd_seq_line_pkg;

    // code 3 has no name of its own and is sent as NRZ
    typedef enum logic [1:0] {
        NRZ          = 2'd0,
        MANCH_IEEE   = 2'd1,  // one is low then high
        MANCH_THOMAS = 2'd2   // one is high then low
    } line_mode_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,  // fetch of byte 0
        SEND = 2'd2
    } eng_state_e;

endpackage

// ==== hw/cmd_mem_if.sv ====
/* one requester port of the command memory, grant in the request cycle,
   read data one cycle after the grant */
`timescale 1ns/1ps

interface cmd_mem_if;

    logic                               req;
    logic                               we;
    logic [cmd_seq_reg_pkg::MEM_AW-1:0] addr;
    logic [cmd_seq_reg_pkg::DATA_W-1:0] wdata;
    logic                               gnt;
    logic [cmd_seq_reg_pkg::DATA_W-1:0] rdata;

    // requester keeps req and fields stable until gnt
    modport requester (output req, we, addr, wdata, input gnt, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rdata);

endinterface

// ==== hw/cmd_seq_regs.sv ====
/* APB slave of the command sequencer: configuration bytes, start and soft reset,
   and the memory window forwarded as held requests on the bus memory port */
`timescale 1ns/1ps

module cmd_seq_regs (
    input  logic                               CMD_CLK_IN,
    input  logic                               RST_CMD_CLK,
    input  logic [cmd_seq_reg_pkg::ADDR_W-1:0] paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [cmd_seq_reg_pkg::DATA_W-1:0] pwdata,
    output logic [cmd_seq_reg_pkg::DATA_W-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr,
    cmd_mem_if.requester                       mem,
    output logic                               start,
    output logic                               soft_rst,
    output cmd_seq_reg_pkg::ctrl_byte_u        ctrl,
    output logic [15:0]                        size_bits,
    output logic [15:0]                        repeat_count,
    output logic [15:0]                        prefix_bits,
    output logic [15:0]                        suffix_bits,
    input  logic                               busy
);

    logic                               access;
    logic                               is_reg;
    logic                               is_mem;
    logic                               rd_wait;  // read granted, data next cycle
    logic [cmd_seq_reg_pkg::ADDR_W-1:0] mem_off;

    assign access  = psel && penable;
    assign is_reg  = paddr <= cmd_seq_reg_pkg::OFF_SUF_HI;
    assign mem_off = paddr - cmd_seq_reg_pkg::OFF_MEM;
    assign is_mem  = (paddr >= cmd_seq_reg_pkg::OFF_MEM) && (mem_off < cmd_seq_reg_pkg::MEM_BYTES);

    assign start    = access && pwrite && (paddr == cmd_seq_reg_pkg::OFF_START);
    assign soft_rst = access && pwrite && (paddr == cmd_seq_reg_pkg::OFF_VERSION);

    // APB holds the access phase, so req stays up until the engine lets us in
    assign mem.req   = access && is_mem && !rd_wait;
    assign mem.we    = pwrite;
    assign mem.addr  = mem_off[cmd_seq_reg_pkg::MEM_AW-1:0];
    assign mem.wdata = pwdata;

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= mem.req && mem.gnt && !pwrite;
        end
    end

    // writes finish on the grant, reads one cycle later
    assign pready  = access && (!is_mem || (pwrite ? mem.gnt : rd_wait));
    assign pslverr = access && !is_reg && !is_mem;

    always_comb begin
        prdata = '0;
        if (is_mem) begin
            prdata = mem.rdata;
        end else begin
            case (paddr)
                cmd_seq_reg_pkg::OFF_VERSION: prdata = cmd_seq_reg_pkg::VERSION;
                cmd_seq_reg_pkg::OFF_START:   prdata = {7'd0, !busy};  // finish flag
                cmd_seq_reg_pkg::OFF_CTRL:    prdata = ctrl.raw;
                cmd_seq_reg_pkg::OFF_SIZE_LO: prdata = size_bits[7:0];
                cmd_seq_reg_pkg::OFF_SIZE_HI: prdata = size_bits[15:8];
                cmd_seq_reg_pkg::OFF_REP_LO:  prdata = repeat_count[7:0];
                cmd_seq_reg_pkg::OFF_REP_HI:  prdata = repeat_count[15:8];
                cmd_seq_reg_pkg::OFF_PRE_LO:  prdata = prefix_bits[7:0];
                cmd_seq_reg_pkg::OFF_PRE_HI:  prdata = prefix_bits[15:8];
                cmd_seq_reg_pkg::OFF_SUF_LO:  prdata = suffix_bits[7:0];
                cmd_seq_reg_pkg::OFF_SUF_HI:  prdata = suffix_bits[15:8];
                default:                      prdata = '0;
            endcase
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            ctrl         <= '0;
            size_bits    <= '0;
            repeat_count <= 16'd1;  // one pass by default
            prefix_bits  <= '0;
            suffix_bits  <= '0;
        end else if (access && pwrite && is_reg) begin
            case (paddr)
                cmd_seq_reg_pkg::OFF_CTRL:    ctrl.raw           <= pwdata;
                cmd_seq_reg_pkg::OFF_SIZE_LO: size_bits[7:0]     <= pwdata;
                cmd_seq_reg_pkg::OFF_SIZE_HI: size_bits[15:8]    <= pwdata;
                cmd_seq_reg_pkg::OFF_REP_LO:  repeat_count[7:0]  <= pwdata;
                cmd_seq_reg_pkg::OFF_REP_HI:  repeat_count[15:8] <= pwdata;
                cmd_seq_reg_pkg::OFF_PRE_LO:  prefix_bits[7:0]   <= pwdata;
                cmd_seq_reg_pkg::OFF_PRE_HI:  prefix_bits[15:8]  <= pwdata;
                cmd_seq_reg_pkg::OFF_SUF_LO:  suffix_bits[7:0]   <= pwdata;
                cmd_seq_reg_pkg::OFF_SUF_HI:  suffix_bits[15:8]  <= pwdata;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/cmd_mem_arbiter.sv ====
/* single-port command memory shared by the engine and the APB side,
   engine has fixed priority, read data returns only on the port that was granted */
`timescale 1ns/1ps

module cmd_mem_arbiter (
    input  logic         CMD_CLK_IN,
    input  logic         RST_CMD_CLK,
    cmd_mem_if.arbiter   eng,
    cmd_mem_if.arbiter   bus
);

    logic [cmd_seq_reg_pkg::DATA_W-1:0] mem [cmd_seq_reg_pkg::MEM_BYTES];
    logic [cmd_seq_reg_pkg::DATA_W-1:0] rd_q;
    logic [cmd_seq_reg_pkg::MEM_AW-1:0] sel_addr;
    logic [cmd_seq_reg_pkg::DATA_W-1:0] sel_wdata;
    logic                               sel_we;
    logic                               eng_gnt_q;
    logic                               bus_gnt_q;

    assign eng.gnt = eng.req;
    assign bus.gnt = bus.req && !eng.req;

    assign sel_addr  = eng.req ? eng.addr : bus.addr;
    assign sel_wdata = eng.req ? eng.wdata : bus.wdata;
    assign sel_we    = eng.req ? eng.we : (bus.req && bus.we);

    always_ff @(posedge CMD_CLK_IN) begin
        if (sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
        if (eng.req || bus.req) begin
            rd_q <= mem[sel_addr];  // read before write on the same address
        end
    end

    // which port owns rd_q this cycle
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            eng_gnt_q <= 1'b0;
            bus_gnt_q <= 1'b0;
        end else begin
            eng_gnt_q <= eng.gnt;
            bus_gnt_q <= bus.gnt;
        end
    end

    assign eng.rdata = eng_gnt_q ? rd_q : '0;
    assign bus.rdata = bus_gnt_q ? rd_q : '0;

endmodule

// ==== hw/cmd_seq_engine.sv ====
/* playback engine: sends prefix once, body repeat_count times and suffix once,
   two cycles per bit, coded as NRZ or Manchester on cmd_data */
`timescale 1ns/1ps

module cmd_seq_engine (
    input  logic                        CMD_CLK_IN,
    input  logic                        RST_CMD_CLK,
    input  logic                        start,
    input  logic                        soft_rst,
    input  logic                        ext_start,
    input  cmd_seq_reg_pkg::ctrl_byte_u ctrl,
    input  logic [15:0]                 size_bits,
    input  logic [15:0]                 repeat_count,
    input  logic [15:0]                 prefix_bits,
    input  logic [15:0]                 suffix_bits,
    cmd_mem_if.requester                mem,
    output logic                        busy,
    output logic                        cmd_ready,
    output logic                        cmd_data,
    output logic                        cmd_start_flag
);

    cmd_seq_line_pkg::eng_state_e       state;
    logic                               half;         // second half-bit
    logic [15:0]                        idx;          // bit on the line
    logic [15:0]                        pass;         // body passes done
    logic [15:0]                        body_end;
    logic [15:0]                        last_body;
    logic [15:0]                        rep_eff;
    logic [15:0]                        nxt;
    logic [12:0]                        upcoming;     // next byte to need
    logic [cmd_seq_reg_pkg::MEM_AW-1:0] shadow_addr;
    logic [7:0]                         cur;          // msb is the bit on the line
    logic [7:0]                         shadow;
    logic [7:0]                         src;
    logic                               passes_left;
    logic                               jump;
    logic                               last_bit;
    logic                               reload;
    logic                               go;
    logic                               fill_q;
    logic                               enc;

    assign body_end    = size_bits - suffix_bits;
    assign last_body   = body_end - 16'd1;
    assign rep_eff     = (repeat_count == '0) ? 16'd1 : repeat_count;
    assign passes_left = pass != rep_eff - 16'd1;
    assign jump        = (idx == last_body) && passes_left;
    assign last_bit    = (idx == size_bits - 16'd1) && !jump;
    assign nxt         = jump ? prefix_bits : idx + 16'd1;
    assign reload      = jump || (nxt[2:0] == 3'd0);

    // the byte holding the end of a body pass that is not the last leads back to the prefix
    assign upcoming = (passes_left && idx < body_end && idx[15:3] == last_body[15:3]) ?
                      prefix_bits[15:3] : idx[15:3] + 13'd1;

    assign go = (start || (ext_start && ctrl.fields.en_ext_start)) &&
                state == cmd_seq_line_pkg::IDLE;

    // shadow refill whenever the next byte changes, granted at once
    assign mem.req   = (state == cmd_seq_line_pkg::LOAD && !half) ||
                       (state == cmd_seq_line_pkg::SEND &&
                        upcoming[cmd_seq_reg_pkg::MEM_AW-1:0] != shadow_addr);
    assign mem.addr  = (state == cmd_seq_line_pkg::LOAD) ? '0 :
                       upcoming[cmd_seq_reg_pkg::MEM_AW-1:0];
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;

    assign src = fill_q ? mem.rdata : shadow;  // bypass when data lands at the crossing

    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK || soft_rst) begin
            state       <= cmd_seq_line_pkg::IDLE;
            half        <= 1'b0;
            idx         <= '0;
            pass        <= '0;
            fill_q      <= 1'b0;
            shadow_addr <= '0;
        end else begin
            fill_q <= mem.gnt;
            if (mem.gnt) begin
                shadow_addr <= mem.addr;
            end
            case (state)
                cmd_seq_line_pkg::IDLE: begin
                    if (go) begin
                        state <= cmd_seq_line_pkg::LOAD;
                        idx   <= '0;
                        pass  <= '0;
                    end
                end
                cmd_seq_line_pkg::LOAD: begin
                    half <= !half;
                    if (half) begin
                        state <= cmd_seq_line_pkg::SEND;
                    end
                end
                cmd_seq_line_pkg::SEND: begin
                    half <= !half;
                    if (half) begin
                        idx <= nxt;
                        if (jump) begin
                            pass <= pass + 16'd1;
                        end
                        if (last_bit) begin
                            state <= cmd_seq_line_pkg::IDLE;
                        end
                    end
                end
                default: state <= cmd_seq_line_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (fill_q) begin
            shadow <= mem.rdata;
        end
        if (state == cmd_seq_line_pkg::LOAD && half) begin
            cur <= mem.rdata;
        end else if (state == cmd_seq_line_pkg::SEND && half) begin
            cur <= reload ? (src << nxt[2:0]) : (cur << 1);
        end
    end

    always_comb begin
        case (cmd_seq_line_pkg::line_mode_e'(ctrl.fields.line_mode))
            cmd_seq_line_pkg::NRZ:          enc = cur[7];
            cmd_seq_line_pkg::MANCH_IEEE:   enc = half ? cur[7] : !cur[7];
            cmd_seq_line_pkg::MANCH_THOMAS: enc = half ? !cur[7] : cur[7];
            default:                        enc = cur[7];
        endcase
    end

    assign cmd_ready      = state == cmd_seq_line_pkg::IDLE;
    assign busy           = !cmd_ready;
    assign cmd_data       = (state == cmd_seq_line_pkg::SEND) && enc;
    assign cmd_start_flag = (state == cmd_seq_line_pkg::SEND) && !half &&
                            idx == prefix_bits && pass == '0 &&
                            !ctrl.fields.dis_start_pulse;

endmodule

// ==== hw/cmd_seq_top.sv ====
/* command sequencer top, APB register port in, serial command line out */
`timescale 1ns/1ps

module cmd_seq_top (
    input  logic                               CMD_CLK_IN,
    input  logic                               RST_CMD_CLK,
    input  logic [cmd_seq_reg_pkg::ADDR_W-1:0] paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [cmd_seq_reg_pkg::DATA_W-1:0] pwdata,
    output logic [cmd_seq_reg_pkg::DATA_W-1:0] prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  logic                               ext_start,
    output logic                               cmd_ready,
    output logic                               cmd_data,
    output logic                               cmd_start_flag
);

    cmd_seq_reg_pkg::ctrl_byte_u ctrl;
    logic                        start;
    logic                        soft_rst;
    logic                        busy;
    logic [15:0]                 size_bits;
    logic [15:0]                 repeat_count;
    logic [15:0]                 prefix_bits;
    logic [15:0]                 suffix_bits;

    cmd_mem_if eng_mem ();
    cmd_mem_if bus_mem ();

    cmd_seq_regs u_regs (
        .CMD_CLK_IN   (CMD_CLK_IN),
        .RST_CMD_CLK  (RST_CMD_CLK),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .mem          (bus_mem.requester),
        .start        (start),
        .soft_rst     (soft_rst),
        .ctrl         (ctrl),
        .size_bits    (size_bits),
        .repeat_count (repeat_count),
        .prefix_bits  (prefix_bits),
        .suffix_bits  (suffix_bits),
        .busy         (busy)
    );

    cmd_seq_engine u_engine (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .RST_CMD_CLK    (RST_CMD_CLK),
        .start          (start),
        .soft_rst       (soft_rst),
        .ext_start      (ext_start),
        .ctrl           (ctrl),
        .size_bits      (size_bits),
        .repeat_count   (repeat_count),
        .prefix_bits    (prefix_bits),
        .suffix_bits    (suffix_bits),
        .mem            (eng_mem.requester),
        .busy           (busy),
        .cmd_ready      (cmd_ready),
        .cmd_data       (cmd_data),
        .cmd_start_flag (cmd_start_flag)
    );

    cmd_mem_arbiter u_arbiter (
        .CMD_CLK_IN  (CMD_CLK_IN),
        .RST_CMD_CLK (RST_CMD_CLK),
        .eng         (eng_mem.arbiter),
        .bus         (bus_mem.arbiter)
    );

endmodule

// ==== dv/cmd_seq_assert.sv ====
/* protocol checks bound into the memory arbiter and the APB register block,
   inputs that do not apply to one side are tied low in its bind */
`timescale 1ns/1ps

module cmd_seq_assert (
    input logic                               clk,
    input logic                               rst,
    input logic                               gnt_a,
    input logic                               gnt_b,
    input logic                               req,
    input logic                               gnt,
    input logic                               we,
    input logic [cmd_seq_reg_pkg::MEM_AW-1:0] addr,
    input logic                               psel,
    input logic                               penable,
    input logic                               pready
);

    int fail_count = 0;  // summed by the testbench at the end

    one_grant: assert property (@(posedge clk) disable iff (rst) !(gnt_a && gnt_b)) else begin
        fail_count++;
        $error("two memory grants in one cycle");
    end

    // a waiting requester keeps its request and fields
    req_held: assert property (@(posedge clk) disable iff (rst)
                               req && !gnt |=> req && $stable(addr) && $stable(we)) else begin
        fail_count++;
        $error("memory request dropped or changed before grant");
    end

    pready_in_access: assert property (@(posedge clk) disable iff (rst)
                                       pready |-> psel && penable) else begin
        fail_count++;
        $error("pready outside an APB access phase");
    end

endmodule

bind cmd_mem_arbiter cmd_seq_assert u_arb_chk (
    .clk (CMD_CLK_IN), .rst (RST_CMD_CLK),
    .gnt_a (eng.gnt), .gnt_b (bus.gnt),
    .req (bus.req), .gnt (bus.gnt), .we (bus.we), .addr (bus.addr),
    .psel (1'b0), .penable (1'b0), .pready (1'b0)
);

bind cmd_seq_regs cmd_seq_assert u_regs_chk (
    .clk (CMD_CLK_IN), .rst (RST_CMD_CLK),
    .gnt_a (1'b0), .gnt_b (mem.gnt),
    .req (mem.req), .gnt (mem.gnt), .we (mem.we), .addr (mem.addr),
    .psel (psel), .penable (penable), .pready (pready)
);

// ==== dv/cmd_seq_tb.sv ====
/* directed testbench for the command sequencer, programs it over APB, loads the memory
   and checks every playback half-bit against a model built from the framing rules */
`timescale 1ns/1ps

module cmd_seq_tb;

    logic        CMD_CLK_IN;
    logic        RST_CMD_CLK;
    logic [15:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;
    logic        ext_start;
    logic        cmd_ready;
    logic        cmd_data;
    logic        cmd_start_flag;

    logic [7:0]  mem_img [256];  // expected memory contents
    logic        exp_q [$];      // expected half-bits of one playback
    int          errors   = 0;
    int          timeouts = 0;
    int          asrt_fails;

    cmd_seq_top u_dut (.*);

    initial begin
        CMD_CLK_IN = 1'b0;
        forever #10 CMD_CLK_IN = ~CMD_CLK_IN;
    end

    task automatic apb_xfer(input logic [15:0] addr, input logic wr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic err);
        int n;
        @(negedge CMD_CLK_IN);
        paddr   = addr;  // setup phase
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge CMD_CLK_IN);
        penable = 1'b1;
        #1;
        // registers and bad addresses answer in the first access cycle
        if (!pready && (addr < 16'd16 || addr >= 16'd272)) begin
            errors++;
            $display("ERROR %0t: access to 0x%04h not ready in its first cycle", $time, addr);
        end
        n = 0;
        while (!pready && n < 40) begin  // memory window may wait behind the engine
            @(negedge CMD_CLK_IN);
            #1;
            n++;
        end
        if (!pready) begin
            timeouts++;
            $display("APB transfer to 0x%04h got no pready within 40 cycles", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge CMD_CLK_IN);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] rd;
        logic       err;
        apb_xfer(addr, 1'b1, data, rd, err);
    endtask

    task automatic apb_read(input logic [15:0] addr, input logic [7:0] exp, input logic exp_err);
        logic [7:0] got;
        logic       err;
        apb_xfer(addr, 1'b0, 8'h00, got, err);
        if (got !== exp || err !== exp_err) begin
            errors++;
            $display("ERROR %0t: read 0x%04h gave 0x%02h err %b, expected 0x%02h err %b",
                     $time, addr, got, err, exp, exp_err);
        end
    endtask

    task automatic configure(input logic [15:0] size, input logic [15:0] rep,
                             input logic [15:0] pre, input logic [15:0] suf,
                             input logic [7:0] ctrl);
        apb_write(16'd2, ctrl);
        apb_write(16'd3, size[7:0]);
        apb_write(16'd4, size[15:8]);
        apb_write(16'd5, rep[7:0]);
        apb_write(16'd6, rep[15:8]);
        apb_write(16'd7, pre[7:0]);
        apb_write(16'd8, pre[15:8]);
        apb_write(16'd9, suf[7:0]);
        apb_write(16'd10, suf[15:8]);
    endtask

    // prefix once, body rep times (0 counts as 1), suffix once, msb first
    task automatic build_model(input int size, input int rep, input int pre, input int suf,
                               input logic [1:0] mode);
        int   i;
        int   p;
        logic b;
        exp_q.delete();
        i = 0;
        p = 0;
        while (i < size) begin
            b = mem_img[i / 8][7 - (i % 8)];
            exp_q.push_back((mode == 2'd1) ? !b : b);  // ieee one is low then high
            exp_q.push_back((mode == 2'd2) ? !b : b);  // thomas one is high then low
            if (i == size - suf - 1 && p < ((rep == 0) ? 1 : rep) - 1) begin
                p++;
                i = pre;
            end else begin
                i++;
            end
        end
    endtask

    task automatic capture_stream(input int flag_at);
        int n;
        int i;
        int flags;
        n     = 0;
        flags = 0;
        while (cmd_ready && n < 100) begin
            @(negedge CMD_CLK_IN);
            n++;
        end
        if (cmd_ready) begin
            timeouts++;
            $display("playback did not start, cmd_ready stayed high for 100 cycles");
            return;
        end
        repeat (2) @(negedge CMD_CLK_IN);  // byte 0 fetch
        for (i = 0; i < exp_q.size(); i++) begin
            if (cmd_data !== exp_q[i]) begin
                errors++;
                $display("ERROR %0t: half-bit %0d is %b, expected %b", $time, i, cmd_data, exp_q[i]);
            end
            if (cmd_start_flag === 1'b1) begin
                flags++;
                if (i != flag_at) begin
                    errors++;
                    $display("ERROR %0t: start flag at half-bit %0d, expected %0d", $time, i, flag_at);
                end
            end
            @(negedge CMD_CLK_IN);
        end
        if (flags != ((flag_at >= 0) ? 1 : 0)) begin
            errors++;
            $display("ERROR %0t: start flag seen %0d times", $time, flags);
        end
        if (cmd_ready !== 1'b1 || cmd_data !== 1'b0) begin
            errors++;
            $display("ERROR %0t: line not idle after the last half-bit", $time);
        end
    endtask

    task automatic pulse_ext_start();
        @(negedge CMD_CLK_IN);
        ext_start = 1'b1;
        @(negedge CMD_CLK_IN);
        ext_start = 1'b0;
    endtask

    // start by register write, optional memory reads while the line runs
    task automatic play(input logic [15:0] size, input logic [15:0] rep, input logic [15:0] pre,
                        input logic [15:0] suf, input logic [7:0] ctrl, input int n_reads);
        int         k;
        logic [7:0] a;
        configure(size, rep, pre, suf, ctrl);
        build_model(size, rep, pre, suf, ctrl[2:1]);
        fork
            capture_stream(ctrl[3] ? -1 : 2 * pre);
            begin
                apb_write(16'd1, 8'h01);
                apb_read(16'd1, 8'h00, 1'b0);  // still busy
                for (k = 0; k < n_reads; k++) begin
                    a = $urandom_range(255);
                    apb_read(16'd16 + a, mem_img[a], 1'b0);
                end
            end
        join
        apb_read(16'd1, 8'h01, 1'b0);
    endtask

    task automatic test_reset_values();
        apb_read(16'd0, 8'h01, 1'b0);
        apb_read(16'd1, 8'h01, 1'b0);
        apb_read(16'd5, 8'h01, 1'b0);
        apb_read(16'd6, 8'h00, 1'b0);
        apb_read(16'd12, 8'h00, 1'b1);   // gap below the window
        apb_read(16'd272, 8'h00, 1'b1);  // one past the last byte
    endtask

    task automatic test_mem_rw();
        int i;
        for (i = 0; i < 256; i++) begin
            mem_img[i] = $urandom_range(255);
            apb_write(16'd16 + i, mem_img[i]);
        end
        for (i = 0; i < 256; i++) begin
            apb_read(16'd16 + i, mem_img[i], 1'b0);
        end
    endtask

    task automatic test_nrz();
        play(16'd40, 16'd3, 16'd5, 16'd7, 8'h00, 0);
    endtask

    task automatic test_manchester();
        play(16'd19, 16'd2, 16'd3, 16'd4, 8'h02, 0);
        play(16'd27, 16'd0, 16'd6, 16'd2, 8'h0C, 0);  // thomas, no start flag
    endtask

    task automatic test_ext_start();
        int n;
        configure(16'd24, 16'd2, 16'd4, 16'd4, 8'h00);
        pulse_ext_start();
        for (n = 0; n < 4; n++) begin
            @(negedge CMD_CLK_IN);
            if (cmd_ready !== 1'b1) begin
                errors++;
                $display("ERROR %0t: ext_start began playback while disabled", $time);
            end
        end
        apb_write(16'd2, 8'h01);
        build_model(24, 2, 4, 4, 2'd0);
        fork
            capture_stream(8);
            pulse_ext_start();
        join
        apb_read(16'd1, 8'h01, 1'b0);
    endtask

    task automatic test_read_during_play();
        play(16'd64, 16'd4, 16'd8, 16'd8, 8'h00, 8);
    endtask

    initial begin
        void'($urandom(98));
        RST_CMD_CLK = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        ext_start   = 1'b0;
        repeat (4) @(negedge CMD_CLK_IN);
        RST_CMD_CLK = 1'b0;
        test_reset_values();
        test_mem_rw();
        test_nrz();
        test_manchester();
        test_ext_start();
        test_read_during_play();
        asrt_fails = u_dut.u_arbiter.u_arb_chk.fail_count + u_dut.u_regs.u_regs_chk.fail_count;
        $display("errors %0d, timeouts %0d, assertion failures %0d", errors, timeouts, asrt_fails);
        if (errors == 0 && timeouts == 0 && asrt_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== cmd_seq_top.f ====
hw/cmd_seq_reg_pkg.sv
hw/cmd_seq_line_pkg.sv
hw/cmd_mem_if.sv
hw/cmd_seq_regs.sv
hw/cmd_mem_arbiter.sv
hw/cmd_seq_engine.sv
hw/cmd_seq_top.sv
dv/cmd_seq_assert.sv
dv/cmd_seq_tb.sv
